// ==== logic/exe_pkg.sv ====
package exe_pkg;

    localparam int DATA_W = 32;
    localparam int REG_W  = 5;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC1_RS,
        SRC1_SA,
        SRC1_PC
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RT,
        SRC2_IMM_SEXT,
        SRC2_IMM_ZEXT,
        SRC2_CONST8
    } src2_sel_t;

    typedef enum logic [1:0] {
        OV_NONE,
        OV_ADD,
        OV_SUB
    } ov_kind_t;

    typedef enum logic [2:0] {
        HILO_NONE,
        HILO_MFHI,
        HILO_MFLO,
        HILO_MTHI,
        HILO_MTLO,
        HILO_MULT,
        HILO_MULTU
    } hilo_op_t;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LW,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_SW,
        MEM_SB,
        MEM_SH
    } mem_op_t;

    typedef logic [4:0] exc_code_t;

    // 31 means no exception
    localparam exc_code_t EXC_NONE = 5'd31;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        ov_kind_t  ov_kind;
        hilo_op_t  hilo_op;
        mem_op_t   mem_op;
        logic      gr_we;
        reg_idx_t  dest;
        logic [15:0] imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
        exc_code_t ex_code;
    } ds_to_es_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_idx_t  dest;
        logic      gr_we;
        mem_op_t   mem_op;
        exc_code_t ex_code;
        word_t     badvaddr;
    } es_to_ms_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {MEM_LW, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {MEM_SW, MEM_SB, MEM_SH};
    endfunction

endpackage

// ==== logic/exe_pipe_reg.sv ====
`timescale 1ns/1ps

module exe_pipe_reg (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  exe_pkg::ds_to_es_t in_bus,
    input  logic               ms_allowin,
    input  logic               ws_ex,
    output logic               es_allowin,
    output logic               es_valid,
    output logic               fire,
    output exe_pkg::ds_to_es_t inst
);

    logic accept;

    // stage never stalls on its own, only on memory back-pressure
    assign es_allowin = !es_valid || ms_allowin;
    assign accept     = in_valid && es_allowin;
    assign fire       = es_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset || ws_ex) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    // held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            inst <= in_bus;
        end
    end

endmodule

// ==== logic/exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::ds_to_es_t inst,
    output exe_pkg::word_t     alu_result,
    output logic               ov_flag
);

    exe_pkg::word_t src1;
    exe_pkg::word_t src2;
    exe_pkg::word_t sum;
    exe_pkg::word_t diff;
    logic [4:0]     shamt;

    always_comb begin
        case (inst.src1_sel)
            exe_pkg::SRC1_SA: src1 = {27'b0, inst.imm[10:6]};
            exe_pkg::SRC1_PC: src1 = inst.pc;
            default:          src1 = inst.rs_value;
        endcase
    end

    always_comb begin
        case (inst.src2_sel)
            exe_pkg::SRC2_IMM_SEXT: src2 = {{16{inst.imm[15]}}, inst.imm};
            exe_pkg::SRC2_IMM_ZEXT: src2 = {16'b0, inst.imm};
            exe_pkg::SRC2_CONST8:   src2 = 32'd8;
            default:                src2 = inst.rt_value;
        endcase
    end

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[4:0];

    always_comb begin
        case (inst.alu_op)
            exe_pkg::ALU_ADD:  alu_result = sum;
            exe_pkg::ALU_SUB:  alu_result = diff;
            exe_pkg::ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            exe_pkg::ALU_SLTU: alu_result = {31'b0, src1 < src2};
            exe_pkg::ALU_AND:  alu_result = src1 & src2;
            exe_pkg::ALU_NOR:  alu_result = ~(src1 | src2);
            exe_pkg::ALU_OR:   alu_result = src1 | src2;
            exe_pkg::ALU_XOR:  alu_result = src1 ^ src2;
            exe_pkg::ALU_SLL:  alu_result = src2 << shamt;
            exe_pkg::ALU_SRL:  alu_result = src2 >> shamt;
            exe_pkg::ALU_SRA:  alu_result = exe_pkg::word_t'($signed(src2) >>> shamt);
            exe_pkg::ALU_LUI:  alu_result = {src2[15:0], 16'b0};
            default:           alu_result = '0;
        endcase
    end

    // signed overflow, checked on the adder itself
    always_comb begin
        case (inst.ov_kind)
            exe_pkg::OV_ADD: begin
                ov_flag = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            end
            exe_pkg::OV_SUB: begin
                ov_flag = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            end
            default: begin
                ov_flag = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/hilo_unit.sv ====
`timescale 1ns/1ps

module hilo_unit (
    input  logic               clk,
    input  logic               reset,
    input  exe_pkg::ds_to_es_t inst,
    input  logic               commit,
    output exe_pkg::word_t     hi,
    output exe_pkg::word_t     lo
);

    exe_pkg::word_t     hi_q;
    exe_pkg::word_t     lo_q;
    logic signed [63:0] prod_s;
    logic [63:0]        prod_u;

    // operands widen to 64 bits in this context
    assign prod_s = $signed(inst.rs_value) * $signed(inst.rt_value);
    assign prod_u = inst.rs_value * inst.rt_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (commit) begin
            case (inst.hilo_op)
                exe_pkg::HILO_MULT: begin
                    hi_q <= prod_s[63:32];
                    lo_q <= prod_s[31:0];
                end
                exe_pkg::HILO_MULTU: begin
                    hi_q <= prod_u[63:32];
                    lo_q <= prod_u[31:0];
                end
                exe_pkg::HILO_MTHI: begin
                    hi_q <= inst.rs_value;
                end
                exe_pkg::HILO_MTLO: begin
                    lo_q <= inst.rs_value;
                end
                default: begin
                    hi_q <= hi_q;
                    lo_q <= lo_q;
                end
            endcase
        end
    end

    // next instruction sees the value written at the previous commit
    assign hi = hi_q;
    assign lo = lo_q;

endmodule

// ==== logic/store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  exe_pkg::ds_to_es_t inst,
    input  exe_pkg::word_t     alu_result,
    input  logic               commit,
    output logic               addr_err,
    output logic [3:0]         data_wstrb,
    output exe_pkg::word_t     data_wdata,
    output logic               data_req,
    output logic               data_wr
);

    logic [1:0] low;
    logic       store;
    logic [3:0] strobe;

    assign low   = alu_result[1:0];
    assign store = exe_pkg::is_store(inst.mem_op);

    always_comb begin
        case (inst.mem_op)
            exe_pkg::MEM_LW,
            exe_pkg::MEM_SW:  addr_err = (low != 2'b00);
            exe_pkg::MEM_LH,
            exe_pkg::MEM_LHU,
            exe_pkg::MEM_SH:  addr_err = low[0];
            default:          addr_err = 1'b0;
        endcase
    end

    // byte lanes
    always_comb begin
        case (inst.mem_op)
            exe_pkg::MEM_SB: strobe = 4'b0001 << low;
            exe_pkg::MEM_SH: strobe = low[1] ? 4'b1100 : 4'b0011;
            exe_pkg::MEM_SW: strobe = 4'b1111;
            default:         strobe = 4'b0000;
        endcase
    end

    always_comb begin
        case (inst.mem_op)
            exe_pkg::MEM_SB: data_wdata = {4{inst.rt_value[7:0]}};
            exe_pkg::MEM_SH: data_wdata = {2{inst.rt_value[15:0]}};
            default:         data_wdata = inst.rt_value;
        endcase
    end

    // one-cycle request on the leaving cycle
    assign data_req   = commit && (inst.mem_op != exe_pkg::MEM_NONE);
    assign data_wr    = store;
    assign data_wstrb = (data_req && store) ? strobe : 4'b0000;

endmodule

// ==== logic/exe_result.sv ====
`timescale 1ns/1ps

module exe_result (
    input  exe_pkg::ds_to_es_t inst,
    input  logic               es_valid,
    input  logic               fire,
    input  exe_pkg::word_t     alu_result,
    input  logic               ov_flag,
    input  logic               addr_err,
    input  exe_pkg::word_t     hi,
    input  exe_pkg::word_t     lo,
    input  logic               ms_ex,
    input  logic               ws_ex,
    output logic               commit,
    output logic               out_valid,
    output exe_pkg::es_to_ms_t out_bus,
    output exe_pkg::reg_idx_t  fwd_dest,
    output exe_pkg::word_t     fwd_data,
    output exe_pkg::word_t     data_addr
);

    exe_pkg::exc_code_t ex_code;
    exe_pkg::word_t     result;

    // earlier stage wins, then overflow, then alignment
    always_comb begin
        if (inst.ex_code != exe_pkg::EXC_NONE) begin
            ex_code = inst.ex_code;
        end else if (ov_flag) begin
            ex_code = exe_pkg::EXC_OV;
        end else if (addr_err) begin
            ex_code = exe_pkg::is_load(inst.mem_op) ? exe_pkg::EXC_ADEL : exe_pkg::EXC_ADES;
        end else begin
            ex_code = exe_pkg::EXC_NONE;
        end
    end

    always_comb begin
        case (inst.hilo_op)
            exe_pkg::HILO_MFHI: result = hi;
            exe_pkg::HILO_MFLO: result = lo;
            default:            result = alu_result;
        endcase
    end

    // no side effects while a later stage is taking an exception
    assign commit    = fire && (ex_code == exe_pkg::EXC_NONE) && !ms_ex && !ws_ex;
    assign out_valid = es_valid;
    assign data_addr = alu_result;

    assign out_bus.pc       = inst.pc;
    assign out_bus.result   = result;
    assign out_bus.dest     = inst.dest;
    assign out_bus.gr_we    = inst.gr_we;
    assign out_bus.mem_op   = inst.mem_op;
    assign out_bus.ex_code  = ex_code;
    assign out_bus.badvaddr = addr_err ? alu_result : '0;

    assign fwd_dest = (es_valid && inst.gr_we) ? inst.dest : '0;
    assign fwd_data = es_valid ? result : '0;

endmodule

// ==== logic/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  exe_pkg::ds_to_es_t   in_bus,
    input  logic                 ms_allowin,
    input  logic                 ms_ex,
    input  logic                 ws_ex,
    output logic                 es_allowin,
    output logic                 out_valid,
    output exe_pkg::es_to_ms_t   out_bus,
    output logic                 data_req,
    output logic                 data_wr,
    output logic [3:0]           data_wstrb,
    output exe_pkg::word_t       data_addr,
    output exe_pkg::word_t       data_wdata,
    output exe_pkg::reg_idx_t    fwd_dest,
    output exe_pkg::word_t       fwd_data
);

    logic               es_valid;
    logic               fire;
    exe_pkg::ds_to_es_t inst;
    exe_pkg::word_t     alu_result;
    logic               ov_flag;
    logic               addr_err;
    exe_pkg::word_t     hi;
    exe_pkg::word_t     lo;
    logic               commit;

    exe_pipe_reg i_pipe_reg (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .ms_allowin (ms_allowin),
        .ws_ex      (ws_ex),
        .es_allowin (es_allowin),
        .es_valid   (es_valid),
        .fire       (fire),
        .inst       (inst)
    );

    exe_alu i_alu (
        .inst       (inst),
        .alu_result (alu_result),
        .ov_flag    (ov_flag)
    );

    hilo_unit i_hilo (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .commit (commit),
        .hi     (hi),
        .lo     (lo)
    );

    store_align i_store_align (
        .inst       (inst),
        .alu_result (alu_result),
        .commit     (commit),
        .addr_err   (addr_err),
        .data_wstrb (data_wstrb),
        .data_wdata (data_wdata),
        .data_req   (data_req),
        .data_wr    (data_wr)
    );

    exe_result i_result (
        .inst       (inst),
        .es_valid   (es_valid),
        .fire       (fire),
        .alu_result (alu_result),
        .ov_flag    (ov_flag),
        .addr_err   (addr_err),
        .hi         (hi),
        .lo         (lo),
        .ms_ex      (ms_ex),
        .ws_ex      (ws_ex),
        .commit     (commit),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .fwd_dest   (fwd_dest),
        .fwd_data   (fwd_data),
        .data_addr  (data_addr)
    );

endmodule

// ==== testbench/exe_stage_chk.sv ====
`timescale 1ns/1ps

module exe_stage_chk (
    input logic               clk,
    input logic               reset,
    input logic               out_valid,
    input exe_pkg::es_to_ms_t out_bus,
    input logic               ms_allowin,
    input logic               ws_ex,
    input logic               data_req,
    input logic               data_wr,
    input logic [3:0]         data_wstrb
);

    // a stalled output holds until memory takes it
    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !ms_allowin && !ws_ex |=> out_valid && $stable(out_bus))
        else $error("out_valid or out_bus changed while stalled");

    a_req_on_fire: assert property (@(posedge clk) disable iff (reset)
        data_req |-> out_valid && ms_allowin)
        else $error("data_req outside a leaving cycle");

    a_strobe: assert property (@(posedge clk) disable iff (reset)
        data_wstrb != 4'b0000 |-> data_req && data_wr)
        else $error("byte strobes without a store request");

    a_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high after reset");

endmodule

bind exe_stage exe_stage_chk i_chk (.*);

// ==== testbench/exe_stage_tb.sv ====
`timescale 1ns/1ps

module exe_stage_tb;

    localparam int N_INSTR = 400;
    localparam int TIMEOUT = N_INSTR * 8 + 16;

    typedef struct packed {
        logic           req;
        logic           wr;
        logic [3:0]     wstrb;
        exe_pkg::word_t addr;
        exe_pkg::word_t wdata;
    } mem_side_t;

    logic               clk;
    logic               reset;
    logic               in_valid;
    exe_pkg::ds_to_es_t in_bus;
    logic               ms_allowin;
    logic               ms_ex;
    logic               ws_ex;
    logic               es_allowin;
    logic               out_valid;
    exe_pkg::es_to_ms_t out_bus;
    logic               data_req;
    logic               data_wr;
    logic [3:0]         data_wstrb;
    exe_pkg::word_t     data_addr;
    exe_pkg::word_t     data_wdata;
    exe_pkg::reg_idx_t  fwd_dest;
    exe_pkg::word_t     fwd_data;

    // instructions held by the stage as seen after the coming edge
    exe_pkg::ds_to_es_t q[$];
    exe_pkg::word_t     model_hi;
    exe_pkg::word_t     model_lo;
    logic               taken;
    int                 n_issued;
    int                 cycles;

    exe_stage i_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .ms_allowin (ms_allowin),
        .ms_ex      (ms_ex),
        .ws_ex      (ws_ex),
        .es_allowin (es_allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .data_req   (data_req),
        .data_wr    (data_wr),
        .data_wstrb (data_wstrb),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .fwd_dest   (fwd_dest),
        .fwd_data   (fwd_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic stop_run(input string why);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s exp=%b got=%b", $time, name, exp, got);
            stop_run("handshake flag mismatch");
        end
    endtask

    task automatic check_bus(input exe_pkg::es_to_ms_t got, input exe_pkg::es_to_ms_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t out_bus exp=%h got=%h", $time, exp, got);
            stop_run("result bundle mismatch");
        end
    endtask

    // an empty stage only has to keep the request and strobes low
    task automatic check_mem(input mem_side_t got, input mem_side_t exp, input logic full);
        if (full ? (got !== exp) : (got.req !== exp.req || got.wstrb !== exp.wstrb)) begin
            $display("ERR t=%0t data_req/wr/wstrb/addr/wdata exp=%h got=%h", $time, exp, got);
            stop_run("memory request mismatch");
        end
    endtask

    task automatic check_fwd(input exe_pkg::reg_idx_t got_dest, input exe_pkg::word_t got_data,
                             input exe_pkg::reg_idx_t exp_dest, input exe_pkg::word_t exp_data);
        if (got_dest !== exp_dest || got_data !== exp_data) begin
            $display("ERR t=%0t fwd_dest/fwd_data exp=%h/%h got=%h/%h",
                     $time, exp_dest, exp_data, got_dest, got_data);
            stop_run("forwarding mismatch");
        end
    endtask

    function automatic exe_pkg::word_t pick_operand();
        case ($urandom_range(0, 3))
            0: return 32'h7fff_ffff - 32'($urandom_range(0, 3));
            1: return 32'h8000_0000 + 32'($urandom_range(0, 3));
            default: return $urandom;
        endcase
    endfunction

    function automatic exe_pkg::ds_to_es_t make_inst();
        exe_pkg::ds_to_es_t d;
        int kind;
        d = '0;
        kind = $urandom_range(0, 9);
        d.rs_value = pick_operand();
        d.rt_value = pick_operand();
        d.imm = 16'($urandom);
        d.pc = $urandom & 32'hffff_fffc;
        d.dest = 5'($urandom);
        d.gr_we = 1'($urandom);
        d.ex_code = ($urandom_range(0, 9) == 0) ? 5'd10 : exe_pkg::EXC_NONE;
        if (kind < 5) begin
            d.alu_op = exe_pkg::alu_op_t'($urandom_range(0, 11));
            d.src1_sel = exe_pkg::src1_sel_t'($urandom_range(0, 2));
            d.src2_sel = exe_pkg::src2_sel_t'($urandom_range(0, 3));
            if (d.alu_op == exe_pkg::ALU_ADD && $urandom_range(0, 1) != 0) begin
                d.ov_kind = exe_pkg::OV_ADD;
            end else if (d.alu_op == exe_pkg::ALU_SUB && $urandom_range(0, 1) != 0) begin
                d.ov_kind = exe_pkg::OV_SUB;
            end
        end else if (kind < 7) begin
            d.hilo_op = exe_pkg::hilo_op_t'($urandom_range(1, 6));
        end else begin
            // address is rs plus the sign-extended offset
            d.mem_op = exe_pkg::mem_op_t'($urandom_range(1, 8));
            d.src2_sel = exe_pkg::SRC2_IMM_SEXT;
            if ($urandom_range(0, 1) != 0) begin
                d.rs_value[1:0] = 2'b00;
                d.imm[1:0] = 2'b00;
            end
        end
        return d;
    endfunction

    function automatic void reference(
        input  exe_pkg::ds_to_es_t d,
        input  logic               commit_ok,
        inout  exe_pkg::word_t     hi,
        inout  exe_pkg::word_t     lo,
        output exe_pkg::es_to_ms_t exp_bus,
        output mem_side_t          exp_mem
    );
        exe_pkg::word_t     a;
        exe_pkg::word_t     b;
        exe_pkg::word_t     r;
        logic [32:0]        wide;
        logic [63:0]        prod;
        logic               ov;
        logic               bad_addr;
        logic               ld;
        logic               st;
        exe_pkg::exc_code_t code;
        a = (d.src1_sel == exe_pkg::SRC1_SA) ? {27'd0, d.imm[10:6]} :
            (d.src1_sel == exe_pkg::SRC1_PC) ? d.pc : d.rs_value;
        case (d.src2_sel)
            exe_pkg::SRC2_IMM_SEXT: b = {{16{d.imm[15]}}, d.imm};
            exe_pkg::SRC2_IMM_ZEXT: b = {16'd0, d.imm};
            exe_pkg::SRC2_CONST8:   b = 32'd8;
            default:                b = d.rt_value;
        endcase
        case (d.alu_op)
            exe_pkg::ALU_ADD:  r = a + b;
            exe_pkg::ALU_SUB:  r = a - b;
            exe_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            exe_pkg::ALU_AND:  r = a & b;
            exe_pkg::ALU_NOR:  r = ~(a | b);
            exe_pkg::ALU_OR:   r = a | b;
            exe_pkg::ALU_XOR:  r = a ^ b;
            exe_pkg::ALU_SLL:  r = b << a[4:0];
            exe_pkg::ALU_SRL:  r = b >> a[4:0];
            exe_pkg::ALU_SRA: begin
                prod = {{32{b[31]}}, b} >> a[4:0];
                r = prod[31:0];
            end
            default:           r = {b[15:0], 16'h0000};
        endcase
        // 33-bit sign-extended result overflows when its top two bits disagree
        wide = (d.ov_kind == exe_pkg::OV_SUB) ? {a[31], a} - {b[31], b}
                                              : {a[31], a} + {b[31], b};
        ov = (d.ov_kind != exe_pkg::OV_NONE) && (wide[32] != wide[31]);
        ld = d.mem_op inside {exe_pkg::MEM_LW, exe_pkg::MEM_LB, exe_pkg::MEM_LBU,
                              exe_pkg::MEM_LH, exe_pkg::MEM_LHU};
        st = d.mem_op inside {exe_pkg::MEM_SW, exe_pkg::MEM_SB, exe_pkg::MEM_SH};
        if (d.mem_op inside {exe_pkg::MEM_LW, exe_pkg::MEM_SW}) begin
            bad_addr = (r[1:0] != 2'b00);
        end else begin
            bad_addr = (d.mem_op inside {exe_pkg::MEM_LH, exe_pkg::MEM_LHU, exe_pkg::MEM_SH})
                       && r[0];
        end
        if (d.ex_code != exe_pkg::EXC_NONE) begin
            code = d.ex_code;
        end else if (ov) begin
            code = exe_pkg::EXC_OV;
        end else if (bad_addr) begin
            code = ld ? exe_pkg::EXC_ADEL : exe_pkg::EXC_ADES;
        end else begin
            code = exe_pkg::EXC_NONE;
        end
        exp_bus.pc = d.pc;
        exp_bus.result = (d.hilo_op == exe_pkg::HILO_MFHI) ? hi :
                         (d.hilo_op == exe_pkg::HILO_MFLO) ? lo : r;
        exp_bus.dest = d.dest;
        exp_bus.gr_we = d.gr_we;
        exp_bus.mem_op = d.mem_op;
        exp_bus.ex_code = code;
        exp_bus.badvaddr = bad_addr ? r : 32'd0;
        exp_mem.req = commit_ok && (code == exe_pkg::EXC_NONE) && (ld || st);
        exp_mem.wr = st;
        exp_mem.addr = r;
        case (d.mem_op)
            exe_pkg::MEM_SB: exp_mem.wstrb = 4'b0001 << r[1:0];
            exe_pkg::MEM_SH: exp_mem.wstrb = r[1] ? 4'b1100 : 4'b0011;
            default:         exp_mem.wstrb = st ? 4'b1111 : 4'b0000;
        endcase
        exp_mem.wstrb = (exp_mem.req && st) ? exp_mem.wstrb : 4'b0000;
        exp_mem.wdata = (d.mem_op == exe_pkg::MEM_SB) ? {4{d.rt_value[7:0]}} :
                        (d.mem_op == exe_pkg::MEM_SH) ? {2{d.rt_value[15:0]}} : d.rt_value;
        if (commit_ok && code == exe_pkg::EXC_NONE) begin
            case (d.hilo_op)
                exe_pkg::HILO_MULT: begin
                    prod = $signed({{32{d.rs_value[31]}}, d.rs_value}) *
                           $signed({{32{d.rt_value[31]}}, d.rt_value});
                    {hi, lo} = prod;
                end
                exe_pkg::HILO_MULTU: begin
                    prod = {32'd0, d.rs_value} * {32'd0, d.rt_value};
                    {hi, lo} = prod;
                end
                exe_pkg::HILO_MTHI: hi = d.rs_value;
                exe_pkg::HILO_MTLO: lo = d.rs_value;
                default: ;
            endcase
        end
    endfunction

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= TIMEOUT) begin
                $display("run did not finish within %0d cycles, the stage seems to hang", TIMEOUT);
                stop_run("timeout");
            end
        end
    end

    // samples mid low phase after the falling-edge inputs have settled
    initial begin
        exe_pkg::es_to_ms_t exp_bus;
        mem_side_t          exp_mem;
        exe_pkg::word_t     hi_t;
        exe_pkg::word_t     lo_t;
        logic               full;
        logic               fire;
        model_hi = '0;
        model_lo = '0;
        forever begin
            @(negedge clk);
            #5;
            if (!reset) begin
                full = (q.size() != 0);
                fire = full && ms_allowin;
                check_flag("out_valid", out_valid, full);
                check_flag("es_allowin", es_allowin, !full || ms_allowin);
                if (full) begin
                    hi_t = model_hi;
                    lo_t = model_lo;
                    reference(q[0], fire && !ms_ex && !ws_ex, hi_t, lo_t, exp_bus, exp_mem);
                    check_bus(out_bus, exp_bus);
                    check_mem({data_req, data_wr, data_wstrb, data_addr, data_wdata},
                              exp_mem, 1'b1);
                    check_fwd(fwd_dest, fwd_data,
                              exp_bus.gr_we ? exp_bus.dest : 5'd0, exp_bus.result);
                    if (fire || ws_ex) begin
                        model_hi = hi_t;
                        model_lo = lo_t;
                        void'(q.pop_front());
                    end
                end else begin
                    exp_mem = '0;
                    check_mem({data_req, data_wr, data_wstrb, data_addr, data_wdata},
                              exp_mem, 1'b0);
                    check_fwd(fwd_dest, fwd_data, 5'd0, 32'd0);
                end
                // a flush also drops whatever is taken at the same edge
                taken = in_valid && (!full || ms_allowin);
                if (taken && !ws_ex) begin
                    q.push_back(in_bus);
                end
            end
        end
    end

    initial begin
        void'($urandom(60));
        reset = 1'b1;
        in_valid = 1'b0;
        in_bus = '0;
        ms_allowin = 1'b0;
        ms_ex = 1'b0;
        ws_ex = 1'b0;
        taken = 1'b0;
        n_issued = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (n_issued < N_INSTR || in_valid || q.size() != 0) begin
            if (in_valid && taken) begin
                in_valid = 1'b0;
            end
            if (!in_valid && n_issued < N_INSTR && $urandom_range(0, 3) != 0) begin
                in_bus = make_inst();
                in_valid = 1'b1;
                n_issued++;
            end
            ws_ex = ($urandom_range(0, 39) == 0);
            ms_ex = ($urandom_range(0, 15) == 0);
            ms_allowin = ($urandom_range(0, 3) != 0);
            @(negedge clk);
        end
        in_valid = 1'b0;
        ws_ex = 1'b0;
        ms_ex = 1'b0;
        repeat (2) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== exe_stage.f ====
logic/exe_pkg.sv
logic/exe_pipe_reg.sv
logic/exe_alu.sv
logic/hilo_unit.sv
logic/store_align.sv
logic/exe_result.sv
logic/exe_stage.sv
testbench/exe_stage_chk.sv
testbench/exe_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module exe_stage_tb -f exe_stage.f \
    && ./obj_dir/Vexe_stage_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
